// File: cpu6502.f
+incdir+src
+incdir+bench
src/cpuPkg.sv
src/opDecoder.sv
src/aluUnit.sv
src/regFile.sv
src/cpuSequencer.sv
src/cpuCore.sv
bench/cpuTb.sv

// File: Makefile
# Verilator build and run of the 6502-style core testbench

VERILATOR ?= verilator
TOP ?= cpuTb
# Build directory of the simulation run
SEED_RUN ?= obj_dir
FILELIST ?= cpu6502.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and pass if RESULT: PASS is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR, TOP, SEED_RUN, FILELIST, VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(SEED_RUN) -f $(FILELIST)
	./$(SEED_RUN)/V$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf $(SEED_RUN)

// File: bench/cpuModel.svh
// Instruction-level reference model of the 6502-style core, included in the testbench
// Runs one instruction per call on its own memory copy and queues every store it makes

`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [7:0] mMem [0:65535];
logic [15:0] mPc;
logic [7:0] mA;
logic [7:0] mX;
logic [7:0] mY;
logic mN;
logic mZ;
logic mC;
logic mV;
// Expected writes as {address, data}
logic [23:0] storeQ [$];

function automatic void setNz(input logic [7:0] v);
	mN = v[7];
	mZ = (v == 8'h00);
endfunction

task automatic addWithCarry(input logic [7:0] m);
	logic [8:0] sum;
	sum = {1'b0, mA} + {1'b0, m} + {8'h00, mC};
	mV = (mA[7] == m[7]) && (sum[7] != mA[7]);
	mC = sum[8];
	mA = sum[7:0];
	setNz(mA);
endtask

task automatic compareReg(input logic [7:0] r, input logic [7:0] m);
	logic [7:0] diff;
	diff = r - m;
	mC = (r >= m);
	setNz(diff);
endtask

task automatic pushStore(input logic [7:0] zp, input logic [7:0] v);
	storeQ.push_back({8'h00, zp, v});
	mMem[{8'h00, zp}] = v;
endtask

task automatic modelStep();
	logic [7:0] opc;
	logic [7:0] opr;
	logic [7:0] val;
	logic [15:0] nextPc;
	logic [15:0] target;
	opc = mMem[mPc];
	opr = mMem[mPc + 16'd1];
	// Immediate forms take the operand byte, zero-page forms read memory
	if (opc inside {8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49,
			8'hC9, 8'hE0, 8'hC0})
		val = opr;
	else
		val = mMem[{8'h00, opr}];
	nextPc = mPc + 16'd2;
	target = mPc + 16'd2 + {{8{opr[7]}}, opr};
	case (opc)
		8'hAA: begin mX = mA; setNz(mX); end
		8'hA8: begin mY = mA; setNz(mY); end
		8'h8A: begin mA = mX; setNz(mA); end
		8'h98: begin mA = mY; setNz(mA); end
		8'hE8: begin mX = mX + 8'd1; setNz(mX); end
		8'hC8: begin mY = mY + 8'd1; setNz(mY); end
		8'hCA: begin mX = mX - 8'd1; setNz(mX); end
		8'h88: begin mY = mY - 8'd1; setNz(mY); end
		8'h18: mC = 1'b0;
		8'h38: mC = 1'b1;
		8'hB8: mV = 1'b0;
		8'hA9, 8'hA5: begin mA = val; setNz(mA); end
		8'hA2, 8'hA6: begin mX = val; setNz(mX); end
		8'hA0, 8'hA4: begin mY = val; setNz(mY); end
		8'h69, 8'h65: addWithCarry(val);
		8'hE9, 8'hE5: addWithCarry(~val);
		8'h29, 8'h25: begin mA = mA & val; setNz(mA); end
		8'h09, 8'h05: begin mA = mA | val; setNz(mA); end
		8'h49, 8'h45: begin mA = mA ^ val; setNz(mA); end
		8'hC9, 8'hC5: compareReg(mA, val);
		8'hE0, 8'hE4: compareReg(mX, val);
		8'hC0, 8'hC4: compareReg(mY, val);
		8'h85: pushStore(opr, mA);
		8'h86: pushStore(opr, mX);
		8'h84: pushStore(opr, mY);
		8'h10: if (!mN) nextPc = target;
		8'h30: if (mN) nextPc = target;
		8'h50: if (!mV) nextPc = target;
		8'h70: if (mV) nextPc = target;
		8'h90: if (!mC) nextPc = target;
		8'hB0: if (mC) nextPc = target;
		8'hD0: if (!mZ) nextPc = target;
		8'hF0: if (mZ) nextPc = target;
		8'h4C: nextPc = {mMem[mPc + 16'd2], opr};
		default: ;
	endcase
	// One-byte implied instructions, unknown codes included
	if (!(opc inside {8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49,
			8'hC9, 8'hE0, 8'hC0, 8'hA5, 8'hA6, 8'hA4, 8'h65, 8'hE5, 8'h25,
			8'h05, 8'h45, 8'hC5, 8'hE4, 8'hC4, 8'h85, 8'h86, 8'h84, 8'h10,
			8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0, 8'h4C}))
		nextPc = mPc + 16'd1;
	mPc = nextPc;
endtask

`endif

// File: bench/cpuTb.sv
// Testbench of the 6502-style core
// Builds a random program from a fixed seed, runs it on the core and on a reference model,
// and compares every opcode fetch address and every store

`timescale 1ns/1ps
`include "cpu6502_config.svh"

module cpuTb;
	localparam int NumInstr = 300;
	// Worst case 4 cycles of 4 ns per instruction, plus startup and loop margin
	localparam int WatchNs = NumInstr * 4 * 4 + 2000;

	logic clk;
	logic rst_n;
	logic [7:0] dataIn;
	logic [7:0] dataOut;
	logic [15:0] addr;
	logic rw;
	logic sync;

	logic [7:0] mem [0:65535];
	logic [31:0] rngState;
	logic [15:0] genPc;
	logic [15:0] patchAt;
	logic [15:0] endAddr;
	logic [23:0] expStore;
	int instrCount;
	int patchLeft;
	int endHits;
	logic patchActive;
	logic done;

	// Implied codes first, then immediates, then zero-page forms
	logic [7:0] pool [0:36] = '{
		8'hAA, 8'hA8, 8'h8A, 8'h98, 8'hE8, 8'hC8, 8'hCA, 8'h88, 8'h18, 8'h38, 8'hB8, 8'hEA,
		8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49, 8'hC9, 8'hE0, 8'hC0,
		8'hA5, 8'hA6, 8'hA4, 8'h65, 8'hE5, 8'h25, 8'h05, 8'h45, 8'hC5, 8'hE4, 8'hC4,
		8'h85, 8'h86, 8'h84
	};
	logic [7:0] branchOps [0:7] = '{
		8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0
	};

	`include "cpuModel.svh"

	cpuCore i_cpuCore (
		.clk(clk),
		.rst_n(rst_n),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.addr(addr),
		.rw(rw),
		.sync(sync)
	);

	// Zero-wait memory
	assign dataIn = mem[addr];

	always @(posedge clk) begin
		if (rst_n && !rw)
			mem[addr] <= dataOut;
	end

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] nextRand();
		rngState = rngState * 32'd1103515245 + 32'd12345;
		return {17'h0, rngState[30:16]};
	endfunction

	task automatic checkEq(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			$display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
			$display("RESULT: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	task automatic putByte(input logic [7:0] b);
		mem[genPc] = b;
		genPc = genPc + 16'd1;
	endtask

	// Ends one instruction and resolves a forward branch whose target is reached
	task automatic closeInstr();
		instrCount = instrCount + 1;
		if (patchActive) begin
			patchLeft = patchLeft - 1;
			if (patchLeft == 0) begin
				mem[patchAt] = 8'(genPc - (patchAt + 16'd1));
				patchActive = 1'b0;
			end
		end
	endtask

	function automatic logic [7:0] storeFor(input logic [7:0] opc);
		case (opc)
			8'h8A, 8'h98, 8'hA9, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49,
			8'hA5, 8'h65, 8'hE5, 8'h25, 8'h05, 8'h45: return 8'h85;
			8'hAA, 8'hE8, 8'hCA, 8'hA2, 8'hA6: return 8'h86;
			8'hA8, 8'hC8, 8'h88, 8'hA0, 8'hA4: return 8'h84;
			default: return 8'h00;
		endcase
	endfunction

	// Taken backward branch into a JMP that leaves the block
	task automatic putBackBlock();
		logic [15:0] base;
		base = genPc;
		putByte(8'h38);
		closeInstr();
		putByte(8'hB0);
		putByte(8'h03);
		closeInstr();
		putByte(8'h4C);
		putByte(base[7:0] + 8'd9);
		putByte(8'((base + 16'd9) >> 8));
		closeInstr();
		putByte(8'h38);
		closeInstr();
		putByte(8'hB0);
		putByte(8'hFA);
		closeInstr();
	endtask

	task automatic buildProgram();
		int r;
		int idx;
		logic [7:0] opc;
		logic [7:0] st;
		genPc = 16'h0200;
		instrCount = 0;
		patchActive = 1'b0;
		while (instrCount < NumInstr) begin
			r = int'(nextRand() % 16);
			if (r < 3 && !patchActive) begin
				putByte(branchOps[nextRand() % 8]);
				patchAt = genPc;
				putByte(8'h00);
				closeInstr();
				patchActive = 1'b1;
				patchLeft = 1 + int'(nextRand() % 4);
			end else if (r == 3 && !patchActive) begin
				putBackBlock();
			end else begin
				idx = int'(nextRand() % 37);
				opc = pool[idx];
				putByte(opc);
				if (idx >= 12)
					putByte(8'(nextRand()));
				closeInstr();
				st = storeFor(opc);
				if (st != 8'h00 && nextRand() % 2 == 1) begin
					putByte(st);
					putByte(8'(nextRand()));
					closeInstr();
				end
			end
		end
		if (patchActive)
			mem[patchAt] = 8'(genPc - (patchAt + 16'd1));
		endAddr = genPc;
		putByte(8'h4C);
		putByte(endAddr[7:0]);
		putByte(endAddr[15:8]);
	endtask

	task automatic buildMemory();
		int i;
		for (i = 0; i < 65536; i++)
			mem[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
		for (i = 0; i < 256; i++)
			mem[i] = 8'(nextRand());
		mem[`CPU_RESET_VEC_LO] = 8'h00;
		mem[`CPU_RESET_VEC_HI] = 8'h02;
		buildProgram();
		for (i = 0; i < 65536; i++)
			mMem[i] = mem[i];
		mPc = 16'h0200;
		mA = 8'h00;
		mX = 8'h00;
		mY = 8'h00;
		// Status after reset has only Z set
		mN = 1'b0;
		mZ = 1'b1;
		mC = 1'b0;
		mV = 1'b0;
	endtask

	// Stores and fetches are compared at the falling edge, where the bus is stable
	always @(negedge clk) begin
		if (rst_n && !done) begin
			if (!rw) begin
				checkEq(addr[15:8], 0, "write outside the zero page");
				if (storeQ.size() == 0) begin
					$display("Write to %h at %0t ns while the model expects no store",
						addr, $time);
					$display("RESULT: FAIL");
					$fatal(1, "unexpected write");
				end else begin
					expStore = storeQ.pop_front();
					checkEq(addr, expStore[23:8], "store address");
					checkEq(dataOut, expStore[7:0], "store data");
				end
			end
			if (sync) begin
				checkEq(addr, mPc, "opcode fetch address");
				if (addr == endAddr) begin
					endHits = endHits + 1;
					if (endHits == 3)
						done = 1'b1;
				end
				modelStep();
			end
		end
	end

	initial begin
		#(WatchNs);
		$display("Timeout after %0d ns, the core never settled in its final jump loop", WatchNs);
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		rst_n = 1'b0;
		done = 1'b0;
		endHits = 0;
		rngState = 32'd30165;
		buildMemory();
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		// Reset vector low, high, then the first opcode
		@(negedge clk);
		checkEq(addr, `CPU_RESET_VEC_LO, "startup address 0");
		checkEq(rw, 1, "startup rw 0");
		@(negedge clk);
		checkEq(addr, `CPU_RESET_VEC_HI, "startup address 1");
		checkEq(rw, 1, "startup rw 1");
		@(negedge clk);
		checkEq(addr, 16'h0200, "first fetch address");
		checkEq(rw, 1, "startup rw 2");
		wait (done);
		checkEq(storeQ.size(), 0, "stores left in the model");
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: src/cpuCore.sv
// Top level of the multicycle 6502-style core
// Connects decoder, cycle sequencer, registered ALU and register file to the memory bus
// The memory answers dataIn in the same cycle, with no wait states

`timescale 1ns/1ps
`include "cpu6502_config.svh"

module cpuCore (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`CPU_DATA_W-1:0] dataIn,
	output logic [`CPU_DATA_W-1:0] dataOut,
	output logic [`CPU_ADDR_W-1:0] addr,
	output logic                   rw,
	output logic                   sync
);
	import cpuPkg::*;

	cpuOpcode opcode;
	addrMode mode;
	aluOp decOp;
	aluOp aluOpSel;
	regDest dest;
	regDest storeSrc;
	flagMask decFlags;
	flagMask statusFlags;
	logic [`CPU_DATA_W-1:0] regA;
	logic [`CPU_DATA_W-1:0] regX;
	logic [`CPU_DATA_W-1:0] regY;
	logic [`CPU_DATA_W-1:0] aluA;
	logic [`CPU_DATA_W-1:0] aluB;
	logic [`CPU_DATA_W-1:0] aluResult;
	logic aluCin;
	logic aluCarry;
	logic aluOverflow;
	logic opValid;
	logic commitReq;
	logic instrStart;
	logic clearCarry;
	logic setCarry;
	logic clearOverflow;

	opDecoder i_opDecoder (
		.opcode(opcode), .mode(mode), .op(decOp), .dest(dest),
		.flags(decFlags), .storeSrc(storeSrc)
	);

	cpuSequencer i_cpuSequencer (
		.clk(clk), .rst_n(rst_n), .dataIn(dataIn), .mode(mode), .op(decOp),
		.dest(dest), .storeSrc(storeSrc), .regA(regA), .regX(regX), .regY(regY),
		.statusFlags(statusFlags), .aluResult(aluResult), .aluCarry(aluCarry),
		.opcode(opcode), .aluA(aluA), .aluB(aluB), .aluCin(aluCin),
		.aluOpSel(aluOpSel), .opValid(opValid), .commitReq(commitReq),
		.instrStart(instrStart), .clearCarry(clearCarry), .setCarry(setCarry),
		.clearOverflow(clearOverflow), .addr(addr), .dataOut(dataOut), .rw(rw),
		.sync(sync)
	);

	aluUnit i_aluUnit (
		.clk(clk), .rst_n(rst_n), .a(aluA), .b(aluB), .cin(aluCin), .op(aluOpSel),
		.opValid(opValid), .result(aluResult), .carry(aluCarry), .overflow(aluOverflow)
	);

	regFile i_regFile (
		.clk(clk), .rst_n(rst_n), .commitReq(commitReq), .instrStart(instrStart),
		.dest(dest), .flags(decFlags), .aluResult(aluResult), .aluCarry(aluCarry),
		.aluOverflow(aluOverflow), .clearCarry(clearCarry), .setCarry(setCarry),
		.clearOverflow(clearOverflow), .regA(regA), .regX(regX), .regY(regY),
		.statusFlags(statusFlags)
	);

endmodule

// File: src/cpuSequencer.sv
// Cycle sequencer of the core
// Fetches the reset vector, then steps each instruction through its bus cycles
// Owns the PC, the bus outputs, SYNC and the branch page fix-up

`timescale 1ns/1ps
`include "cpu6502_config.svh"

module cpuSequencer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`CPU_DATA_W-1:0] dataIn,
	input  cpuPkg::addrMode        mode,
	input  cpuPkg::aluOp           op,
	input  cpuPkg::regDest         dest,
	input  cpuPkg::regDest         storeSrc,
	input  logic [`CPU_DATA_W-1:0] regA,
	input  logic [`CPU_DATA_W-1:0] regX,
	input  logic [`CPU_DATA_W-1:0] regY,
	input  cpuPkg::flagMask        statusFlags,
	input  logic [`CPU_DATA_W-1:0] aluResult,
	input  logic                   aluCarry,
	output cpuPkg::cpuOpcode       opcode,
	output logic [`CPU_DATA_W-1:0] aluA,
	output logic [`CPU_DATA_W-1:0] aluB,
	output logic                   aluCin,
	output cpuPkg::aluOp           aluOpSel,
	output logic                   opValid,
	output logic                   commitReq,
	output logic                   instrStart,
	output logic                   clearCarry,
	output logic                   setCarry,
	output logic                   clearOverflow,
	output logic [`CPU_ADDR_W-1:0] addr,
	output logic [`CPU_DATA_W-1:0] dataOut,
	output logic                   rw,
	output logic                   sync
);
	import cpuPkg::*;

	seqState state;
	logic [1:0] cnt;
	logic [`CPU_DATA_W-1:0] pcH;
	logic [`CPU_DATA_W-1:0] pcL;
	logic [`CPU_DATA_W-1:0] operandLo;
	logic [`CPU_ADDR_W-1:0] pcInc;
	logic [`CPU_DATA_W-1:0] srcVal;
	logic [`CPU_DATA_W-1:0] destVal;
	logic offNeg;
	logic flagBit;
	logic branchTaken;
	logic fixNeed;
	logic isStore;
	logic implExec;

	function automatic logic [`CPU_DATA_W-1:0] pickReg(input regDest sel,
			input logic [`CPU_DATA_W-1:0] a, input logic [`CPU_DATA_W-1:0] x,
			input logic [`CPU_DATA_W-1:0] y);
		case (sel)
			destA: return a;
			destX: return x;
			destY: return y;
			default: return '0;
		endcase
	endfunction

	assign pcInc = {pcH, pcL} + 1'b1;
	assign srcVal = pickReg(storeSrc, regA, regX, regY);
	assign destVal = pickReg(dest, regA, regX, regY);
	assign isStore = (dest == destNone) && (storeSrc != destNone);
	assign instrStart = (state == stRunning) && (cnt == 2'd0);
	assign implExec = (state == stRunning) && (cnt == 2'd1) && (mode == modeImplied);
	assign clearCarry = implExec && (opcode == opClc);
	assign setCarry = implExec && (opcode == opSec);
	assign clearOverflow = implExec && (opcode == opClv);

	// Opcode bits 7:6 pick N, V, C or Z, bit 5 is the value that takes the branch
	always_comb begin
		case (opcode[7:6])
			2'b00: flagBit = statusFlags.n;
			2'b01: flagBit = statusFlags.v;
			2'b10: flagBit = statusFlags.c;
			default: flagBit = statusFlags.z;
		endcase
	end
	assign branchTaken = (flagBit == opcode[5]);
	// PCL add carried forward, or borrowed on a negative offset
	assign fixNeed = aluCarry ^ offNeg;

	// ALU issue, result comes back at the start of the next cycle
	always_comb begin
		aluA = (op == aluCmp) ? srcVal : destVal;
		aluB = (mode == modeImplied) ? srcVal : dataIn;
		aluCin = statusFlags.c;
		aluOpSel = aluPass;
		opValid = 1'b0;
		commitReq = 1'b0;
		if (state == stRunning && cnt == 2'd1) begin
			if ((mode == modeImplied || mode == modeImmediate) && dest != destNone) begin
				aluOpSel = op;
				opValid = 1'b1;
				commitReq = 1'b1;
			end else if (mode == modeBranch && branchTaken) begin
				// Low byte of the address after the offset byte
				aluA = pcInc[`CPU_DATA_W-1:0];
				aluCin = 1'b0;
				aluOpSel = op;
				opValid = 1'b1;
			end
		end else if (state == stRunning && cnt == 2'd2) begin
			if (mode == modeZeroPage && dest != destNone) begin
				aluOpSel = op;
				opValid = 1'b1;
				commitReq = 1'b1;
			end else if (mode == modeBranch && fixNeed) begin
				aluA = pcH;
				aluOpSel = offNeg ? aluDec : aluInc;
				opValid = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= stStartup;
			cnt <= 2'd0;
			opcode <= opNop;
			addr <= `CPU_RESET_VEC_LO;
			rw <= 1'b1;
			sync <= 1'b0;
		end else if (state == stStartup) begin
			if (cnt == 2'd0) begin
				pcL <= dataIn;
				addr <= `CPU_RESET_VEC_HI;
				cnt <= 2'd1;
			end else begin
				pcH <= dataIn;
				addr <= {dataIn, pcL};
				state <= stRunning;
				cnt <= 2'd0;
				sync <= 1'b1;
			end
		end else begin
			case (cnt)
				2'd0: begin
					opcode <= cpuOpcode'(dataIn);
					sync <= 1'b0;
					{pcH, pcL} <= pcInc;
					addr <= pcInc;
					cnt <= 2'd1;
				end
				2'd1: begin
					case (mode)
						modeImplied: begin
							addr <= {pcH, pcL};
							sync <= 1'b1;
							cnt <= 2'd0;
						end
						modeZeroPage: begin
							{pcH, pcL} <= pcInc;
							addr <= {8'h00, dataIn};
							cnt <= 2'd2;
							if (isStore) begin
								rw <= 1'b0;
								dataOut <= srcVal;
							end
						end
						default: begin
							// Immediate, branch offset and JMP low byte
							{pcH, pcL} <= pcInc;
							addr <= pcInc;
							operandLo <= dataIn;
							offNeg <= dataIn[7];
							if (mode == modeJump || (mode == modeBranch && branchTaken)) begin
								cnt <= 2'd2;
							end else begin
								sync <= 1'b1;
								cnt <= 2'd0;
							end
						end
					endcase
				end
				2'd2: begin
					if (mode == modeJump) begin
						{pcH, pcL} <= {dataIn, operandLo};
						addr <= {dataIn, operandLo};
					end else if (mode == modeBranch) begin
						pcL <= aluResult;
						addr <= {pcH, aluResult};
					end else begin
						addr <= {pcH, pcL};
					end
					rw <= 1'b1;
					if (mode == modeBranch && fixNeed) begin
						cnt <= 2'd3;
					end else begin
						sync <= 1'b1;
						cnt <= 2'd0;
					end
				end
				default: begin
					// Page crossed, corrected high byte from the ALU
					pcH <= aluResult;
					addr <= {aluResult, pcL};
					sync <= 1'b1;
					cnt <= 2'd0;
				end
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		!rw |-> (mode == modeZeroPage && cnt == 2'd2 && isStore));

	assert property (@(posedge clk) disable iff (!rst_n)
		(state == stStartup) |-> !sync);

endmodule

// File: src/regFile.sv
// A, X, Y and the N, Z, C, V flags
// A commit at execute time is held pending and written at the next instruction start
// CLC, SEC and CLV arrive as single-cycle pulses

`timescale 1ns/1ps
`include "cpu6502_config.svh"

module regFile (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   commitReq,
	input  logic                   instrStart,
	input  cpuPkg::regDest         dest,
	input  cpuPkg::flagMask        flags,
	input  logic [`CPU_DATA_W-1:0] aluResult,
	input  logic                   aluCarry,
	input  logic                   aluOverflow,
	input  logic                   clearCarry,
	input  logic                   setCarry,
	input  logic                   clearOverflow,
	output logic [`CPU_DATA_W-1:0] regA,
	output logic [`CPU_DATA_W-1:0] regX,
	output logic [`CPU_DATA_W-1:0] regY,
	output cpuPkg::flagMask        statusFlags
);
	import cpuPkg::*;

	localparam logic [7:0] StatusInit = `CPU_STATUS_INIT;

	logic [`CPU_DATA_W-1:0] aReg;
	logic [`CPU_DATA_W-1:0] xReg;
	logic [`CPU_DATA_W-1:0] yReg;
	regDest pendDest;
	flagMask pendFlags;
	logic pendValid;
	logic applyNow;

	// ALU output is valid exactly in the cycle the pending write lands
	assign applyNow = instrStart && pendValid;

	// Pending value forwarded during its write cycle
	assign regA = (applyNow && pendDest == destA) ? aluResult : aReg;
	assign regX = (applyNow && pendDest == destX) ? aluResult : xReg;
	assign regY = (applyNow && pendDest == destY) ? aluResult : yReg;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			aReg <= '0;
			xReg <= '0;
			yReg <= '0;
			statusFlags <= '{n: StatusInit[7], z: StatusInit[1],
				c: StatusInit[0], v: StatusInit[6]};
			pendValid <= 1'b0;
			pendDest <= destNone;
			pendFlags <= '0;
		end else begin
			if (commitReq) begin
				pendValid <= 1'b1;
				pendDest <= dest;
				pendFlags <= flags;
			end else if (instrStart) begin
				pendValid <= 1'b0;
			end
			if (applyNow) begin
				case (pendDest)
					destA: aReg <= aluResult;
					destX: xReg <= aluResult;
					destY: yReg <= aluResult;
					default: ;
				endcase
				if (pendFlags.n) statusFlags.n <= aluResult[`CPU_DATA_W-1];
				if (pendFlags.z) statusFlags.z <= (aluResult == '0);
				if (pendFlags.c) statusFlags.c <= aluCarry;
				if (pendFlags.v) statusFlags.v <= aluOverflow;
			end
			if (clearCarry) statusFlags.c <= 1'b0;
			if (setCarry) statusFlags.c <= 1'b1;
			if (clearOverflow) statusFlags.v <= 1'b0;
		end
	end

	// Each instruction ends with its commit, so the previous one has drained by then
	assert property (@(posedge clk) disable iff (!rst_n)
		commitReq |-> !pendValid);

endmodule

// File: src/aluUnit.sv
// Registered 8-bit ALU
// Result, carry and overflow appear one cycle after an operation with opValid high
// Overflow only comes from add and subtract

`timescale 1ns/1ps
`include "cpu6502_config.svh"

module aluUnit (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`CPU_DATA_W-1:0] a,
	input  logic [`CPU_DATA_W-1:0] b,
	input  logic                   cin,
	input  cpuPkg::aluOp           op,
	input  logic                   opValid,
	output logic [`CPU_DATA_W-1:0] result,
	output logic                   carry,
	output logic                   overflow
);
	import cpuPkg::*;

	logic [`CPU_DATA_W-1:0] operandB;
	logic [`CPU_DATA_W-1:0] nextResult;
	logic [`CPU_DATA_W:0] sum;
	logic carryIn;
	logic nextOverflow;

	// Every arithmetic op goes through one adder
	always_comb begin
		operandB = b;
		carryIn = cin;
		case (op)
			aluSub: operandB = ~b;
			aluCmp: begin
				operandB = ~b;
				carryIn = 1'b1;
			end
			aluInc: begin
				operandB = '0;
				carryIn = 1'b1;
			end
			aluDec: begin
				operandB = '1;
				carryIn = 1'b0;
			end
			default: ;
		endcase
		sum = {1'b0, a} + {1'b0, operandB} + {{`CPU_DATA_W{1'b0}}, carryIn};
		case (op)
			aluPass: nextResult = b;
			aluAnd: nextResult = a & b;
			aluOr: nextResult = a | b;
			aluEor: nextResult = a ^ b;
			default: nextResult = sum[`CPU_DATA_W-1:0];
		endcase
		// Same-sign operands giving a result of the other sign
		nextOverflow = (op == aluAdd || op == aluSub) &&
			(a[`CPU_DATA_W-1] == operandB[`CPU_DATA_W-1]) &&
			(sum[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
			carry <= 1'b0;
			overflow <= 1'b0;
		end else if (opValid) begin
			result <= nextResult;
			carry <= sum[`CPU_DATA_W];
			overflow <= nextOverflow;
		end
	end

endmodule

// File: src/opDecoder.sv
// Combinational opcode decoder
// Gives the address mode, ALU operation, destination, updated flags and source register
// Codes not listed decode as a two-cycle implied NOP

`timescale 1ns/1ps

module opDecoder (
	input  cpuPkg::cpuOpcode opcode,
	output cpuPkg::addrMode  mode,
	output cpuPkg::aluOp     op,
	output cpuPkg::regDest   dest,
	output cpuPkg::flagMask  flags,
	output cpuPkg::regDest   storeSrc
);
	import cpuPkg::*;

	localparam flagMask FlagsNz = '{n: 1'b1, z: 1'b1, c: 1'b0, v: 1'b0};
	localparam flagMask FlagsNzc = '{n: 1'b1, z: 1'b1, c: 1'b1, v: 1'b0};
	localparam flagMask FlagsAll = '{n: 1'b1, z: 1'b1, c: 1'b1, v: 1'b1};

	always_comb begin
		case (opcode)
			opLdaImm, opLdxImm, opLdyImm, opAdcImm, opSbcImm, opAndImm,
			opOraImm, opEorImm, opCmpImm, opCpxImm, opCpyImm:
				mode = modeImmediate;
			opLdaZp, opLdxZp, opLdyZp, opAdcZp, opSbcZp, opAndZp, opOraZp,
			opEorZp, opCmpZp, opCpxZp, opCpyZp, opStaZp, opStxZp, opStyZp:
				mode = modeZeroPage;
			opBpl, opBmi, opBvc, opBvs, opBcc, opBcs, opBne, opBeq:
				mode = modeBranch;
			opJmpAbs: mode = modeJump;
			default: mode = modeImplied;
		endcase
	end

	// storeSrc also names the source of transfers and compares
	always_comb begin
		op = aluPass;
		dest = destNone;
		flags = '0;
		storeSrc = destNone;
		case (opcode)
			opLdaImm, opLdaZp: begin dest = destA; flags = FlagsNz; end
			opLdxImm, opLdxZp: begin dest = destX; flags = FlagsNz; end
			opLdyImm, opLdyZp: begin dest = destY; flags = FlagsNz; end
			opTax: begin dest = destX; storeSrc = destA; flags = FlagsNz; end
			opTay: begin dest = destY; storeSrc = destA; flags = FlagsNz; end
			opTxa: begin dest = destA; storeSrc = destX; flags = FlagsNz; end
			opTya: begin dest = destA; storeSrc = destY; flags = FlagsNz; end
			opInx: begin op = aluInc; dest = destX; flags = FlagsNz; end
			opIny: begin op = aluInc; dest = destY; flags = FlagsNz; end
			opDex: begin op = aluDec; dest = destX; flags = FlagsNz; end
			opDey: begin op = aluDec; dest = destY; flags = FlagsNz; end
			opAdcImm, opAdcZp: begin op = aluAdd; dest = destA; flags = FlagsAll; end
			opSbcImm, opSbcZp: begin op = aluSub; dest = destA; flags = FlagsAll; end
			opAndImm, opAndZp: begin op = aluAnd; dest = destA; flags = FlagsNz; end
			opOraImm, opOraZp: begin op = aluOr; dest = destA; flags = FlagsNz; end
			opEorImm, opEorZp: begin op = aluEor; dest = destA; flags = FlagsNz; end
			opCmpImm, opCmpZp: begin
				op = aluCmp;
				dest = destFlagsOnly;
				storeSrc = destA;
				flags = FlagsNzc;
			end
			opCpxImm, opCpxZp: begin
				op = aluCmp;
				dest = destFlagsOnly;
				storeSrc = destX;
				flags = FlagsNzc;
			end
			opCpyImm, opCpyZp: begin
				op = aluCmp;
				dest = destFlagsOnly;
				storeSrc = destY;
				flags = FlagsNzc;
			end
			opStaZp: storeSrc = destA;
			opStxZp: storeSrc = destX;
			opStyZp: storeSrc = destY;
			// PCL plus offset for a taken branch
			opBpl, opBmi, opBvc, opBvs, opBcc, opBcs, opBne, opBeq: op = aluPcAdd;
			default: ;
		endcase
	end

endmodule

// File: src/cpuPkg.sv
// Shared types of the 6502-style core
// Imported by the decoder, sequencer, ALU, register file and the top level

package cpuPkg;

	// Supported opcodes by their 6502 encoding
	typedef enum logic [7:0] {
		opTax = 8'hAA, opTay = 8'hA8, opTxa = 8'h8A, opTya = 8'h98,
		opInx = 8'hE8, opIny = 8'hC8, opDex = 8'hCA, opDey = 8'h88,
		opClc = 8'h18, opSec = 8'h38, opClv = 8'hB8, opNop = 8'hEA,
		opLdaImm = 8'hA9, opLdxImm = 8'hA2, opLdyImm = 8'hA0,
		opAdcImm = 8'h69, opSbcImm = 8'hE9,
		opAndImm = 8'h29, opOraImm = 8'h09, opEorImm = 8'h49,
		opCmpImm = 8'hC9, opCpxImm = 8'hE0, opCpyImm = 8'hC0,
		opLdaZp = 8'hA5, opLdxZp = 8'hA6, opLdyZp = 8'hA4,
		opAdcZp = 8'h65, opSbcZp = 8'hE5,
		opAndZp = 8'h25, opOraZp = 8'h05, opEorZp = 8'h45,
		opCmpZp = 8'hC5, opCpxZp = 8'hE4, opCpyZp = 8'hC4,
		opStaZp = 8'h85, opStxZp = 8'h86, opStyZp = 8'h84,
		opBpl = 8'h10, opBmi = 8'h30, opBvc = 8'h50, opBvs = 8'h70,
		opBcc = 8'h90, opBcs = 8'hB0, opBne = 8'hD0, opBeq = 8'hF0,
		opJmpAbs = 8'h4C
	} cpuOpcode;

	typedef enum logic [2:0] {
		modeImplied,
		modeImmediate,
		modeZeroPage,
		modeBranch,
		modeJump
	} addrMode;

	typedef enum logic [3:0] {
		aluPass, aluAdd, aluSub, aluAnd, aluOr,
		aluEor, aluInc, aluDec, aluCmp, aluPcAdd
	} aluOp;

	// Register written by an instruction, also used as a source select
	typedef enum logic [2:0] {
		destNone,
		destA,
		destX,
		destY,
		destFlagsOnly
	} regDest;

	typedef enum logic [1:0] {
		stStartup,
		stRunning
	} seqState;

	// Flags touched by an instruction, doubles as the status register
	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flagMask;

endpackage

// File: src/cpu6502_config.svh
// Widths, reset vector addresses and the status reset value of the 6502-style core
// Included by every module that sizes the bus or loads reset values

`ifndef CPU6502_CONFIG_SVH
`define CPU6502_CONFIG_SVH

// Bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// Reset vector, low byte then high byte
`define CPU_RESET_VEC_LO 16'hFFFC
`define CPU_RESET_VEC_HI 16'hFFFD

// P register image after reset
// Bit layout follows the 6502 status byte, only N, Z, C and V are kept
`define CPU_STATUS_INIT 8'h16

`endif
